// File: hw/dispatch.sv
// dispatch stage: steers decoded packets to the alu or mul buffer
// issue is gated by the staller and by room in the chosen buffer
`timescale 1ns/100ps

module dispatch import pipe_pkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  logic    flush,
    input  logic    commit_fire,
    input  logic    dec_valid,
    output logic    dec_ready,
    input  op_pkt_t dec_pkt,
    output logic    alu_valid,
    input  logic    alu_ready,
    output op_pkt_t alu_pkt,
    output logic    mul_valid,
    input  logic    mul_ready,
    output op_pkt_t mul_pkt
);
    logic issue_ok;
    logic issue_fire;
    logic is_mul;
    logic alu_in_valid;
    logic alu_in_ready;
    logic mul_in_valid;
    logic mul_in_ready;

    assign is_mul     = (dec_pkt.ex_type == ex_mul);
    assign dec_ready  = issue_ok && (is_mul ? mul_in_ready : alu_in_ready);
    assign issue_fire = dec_valid && dec_ready;

    assign alu_in_valid = issue_fire && !is_mul;
    assign mul_in_valid = issue_fire && is_mul;

    issue_staller staller (
        .clk         (clk),
        .reset       (reset),
        .flush       (flush),
        .issue_fire  (issue_fire),
        .is_branch   (dec_pkt.is_branch),
        .commit_fire (commit_fire),
        .issue_ok    (issue_ok)
    );

    unit_buffer alu_buffer (
        .clk       (clk),
        .reset     (reset),
        .flush     (flush),
        .valid_in  (alu_in_valid),
        .ready_in  (alu_in_ready),
        .data_in   (dec_pkt),
        .valid_out (alu_valid),
        .ready_out (alu_ready),
        .data_out  (alu_pkt)
    );

    unit_buffer mul_buffer (
        .clk       (clk),
        .reset     (reset),
        .flush     (flush),
        .valid_in  (mul_in_valid),
        .ready_in  (mul_in_ready),
        .data_in   (dec_pkt),
        .valid_out (mul_valid),
        .ready_out (mul_ready),
        .data_out  (mul_pkt)
    );

endmodule

// File: hw/instr_decode.sv
// decode stage: one register between fetch and dispatch
// splits the word by opcode and finds the last active thread
`timescale 1ns/100ps
`include "simt_defines.svh"

module instr_decode import isa_pkg::*, pipe_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       in_valid,
    output logic       in_ready,
    input  fetch_pkt_t in_pkt,
    output logic       dec_valid,
    input  logic       dec_ready,
    output op_pkt_t    dec_pkt
);
    instr_u           word;
    op_pkt_t          next_pkt;
    logic [TID_W-1:0] last_tid;

    assign word = in_pkt.instr;

    // highest set mask bit wins
    always_comb begin
        last_tid = '0;
        for (int i = 0; i < `NUM_THREADS; i++) begin
            if (in_pkt.tmask[i]) begin
                last_tid = TID_W'(i);
            end
        end
    end

    always_comb begin
        next_pkt           = '0;
        next_pkt.tmask     = in_pkt.tmask;
        next_pkt.pc        = in_pkt.pc;
        next_pkt.last_tid  = last_tid;
        next_pkt.rs1_data  = in_pkt.rs1_data;
        next_pkt.rs2_data  = in_pkt.rs2_data;
        case (word.r.opcode)
            op_beq: begin
                next_pkt.ex_type   = ex_alu;
                next_pkt.fn        = fn_sub;
                next_pkt.is_branch = 1'b1;
                next_pkt.offset    = word.b.offset;
            end
            op_mul: begin
                next_pkt.ex_type = ex_mul;
                next_pkt.fn      = word.r.fn;
                next_pkt.rd      = word.r.rd;
                next_pkt.wb      = 1'b1;
            end
            default: begin
                // unknown opcodes run as alu ops without writeback
                next_pkt.ex_type = ex_alu;
                next_pkt.fn      = word.r.fn;
                next_pkt.rd      = word.r.rd;
                next_pkt.wb      = (word.r.opcode == op_alu);
            end
        endcase
    end

    assign in_ready = !dec_valid || dec_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            dec_valid <= 1'b0;
        end else if (in_valid && in_ready) begin
            dec_valid <= 1'b1;
        end else if (dec_ready) begin
            dec_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            dec_pkt <= next_pkt;
        end
    end

    // a warp never issues with every thread masked off
    assert property (@(posedge clk) disable iff (reset)
        (in_valid && in_ready) |-> (in_pkt.tmask != '0));

endmodule

// File: hw/isa_pkg.sv
// instruction word layout for the simt slice
// the opcode sits in the top nibble of both forms
package isa_pkg;

    typedef enum logic [3:0] {
        op_alu = 4'h1,
        op_mul = 4'h2,
        op_beq = 4'h3
    } opcode_t;

    typedef enum logic [1:0] {
        fn_add = 2'd0,
        fn_sub = 2'd1,
        fn_and = 2'd2,
        fn_xor = 2'd3
    } alu_fn_t;

    // register form, used by alu and mul
    typedef struct packed {
        opcode_t     opcode;
        logic [4:0]  rd;
        alu_fn_t     fn;
        logic [20:0] pad;
    } r_form_t;

    // branch form, offset counts words
    typedef struct packed {
        opcode_t            opcode;
        logic [11:0]        pad;
        logic signed [15:0] offset;
    } b_form_t;

    typedef union packed {
        r_form_t r;
        b_form_t b;
    } instr_u;

endpackage

// File: hw/issue_staller.sv
// counts instructions between issue and commit and holds back issue
// so that a branch always runs through execute on its own
`timescale 1ns/100ps
`include "simt_defines.svh"

module issue_staller (
    input  logic clk,
    input  logic reset,
    input  logic flush,
    input  logic issue_fire,
    input  logic is_branch,
    input  logic commit_fire,
    output logic issue_ok
);
    localparam int CW = $clog2(`MAX_INFLIGHT + 1);

    logic [CW-1:0] count;
    logic          branch_pending;

    assign issue_ok = (count < CW'(`MAX_INFLIGHT))
                   && !branch_pending
                   && !(is_branch && (count != '0));

    always_ff @(posedge clk) begin
        if (reset) begin
            count          <= '0;
            branch_pending <= 1'b0;
        end else if (flush) begin
            // only the branch itself is left in flight
            count          <= commit_fire ? CW'(0) : CW'(1);
            branch_pending <= branch_pending && !commit_fire;
        end else begin
            case ({issue_fire, commit_fire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            if (issue_fire && is_branch) begin
                branch_pending <= 1'b1;
            end else if (commit_fire && (count == CW'(1))) begin
                branch_pending <= 1'b0;
            end
        end
    end

    assert property (@(posedge clk) disable iff (reset)
        commit_fire |-> (count != '0));

endmodule

// File: hw/pipe_pkg.sv
// packet types passed between pipeline stages
// fetch packet in, operand packet through dispatch, result packet to commit
`include "simt_defines.svh"

package pipe_pkg;
    import isa_pkg::*;

    localparam int TID_W = $clog2(`NUM_THREADS);

    typedef logic [`NUM_THREADS-1:0][`XLEN-1:0] lane_data_t;

    typedef enum logic {
        ex_alu = 1'b0,
        ex_mul = 1'b1
    } ex_type_t;

    typedef struct packed {
        logic [31:0]              instr;
        logic [`NUM_THREADS-1:0]  tmask;
        logic [15:0]              pc;
        lane_data_t               rs1_data;
        lane_data_t               rs2_data;
    } fetch_pkt_t;

    typedef struct packed {
        ex_type_t                 ex_type;
        alu_fn_t                  fn;
        logic                     is_branch;
        logic [4:0]               rd;
        logic                     wb;
        logic [`NUM_THREADS-1:0]  tmask;
        logic [15:0]              pc;
        logic signed [15:0]       offset;
        logic [TID_W-1:0]         last_tid;
        lane_data_t               rs1_data;
        lane_data_t               rs2_data;
    } op_pkt_t;

    // inactive lanes carry zero
    typedef struct packed {
        logic [15:0]              pc;
        logic [4:0]               rd;
        logic [`NUM_THREADS-1:0]  tmask;
        logic                     wb;
        lane_data_t               data;
    } res_pkt_t;

endpackage

// File: hw/result_arbiter.sv
// merges alu and mul results onto the single commit port
// mul wins when both are valid, since it has waited longest
`timescale 1ns/100ps

module result_arbiter import pipe_pkg::*; (
    input  logic     alu_valid,
    output logic     alu_ready,
    input  res_pkt_t alu_res,
    input  logic     mul_valid,
    output logic     mul_ready,
    input  res_pkt_t mul_res,
    output logic     commit_valid,
    input  logic     commit_ready,
    output res_pkt_t commit_pkt
);
    assign commit_valid = alu_valid || mul_valid;
    assign commit_pkt   = mul_valid ? mul_res : alu_res;

    assign mul_ready = commit_ready;
    assign alu_ready = commit_ready && !mul_valid;

    // every committed result belongs to at least one thread
    always_comb begin
        assert (!commit_valid || (commit_pkt.tmask != '0))
            else $error("commit with an empty thread mask");
    end

endmodule

// File: hw/simt_alu.sv
// single-cycle per-thread alu, also resolves beq
// a taken branch pulses redirect with the result, which flushes the buffers
`timescale 1ns/100ps
`include "simt_defines.svh"

module simt_alu import isa_pkg::*, pipe_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        op_valid,
    output logic        op_ready,
    input  op_pkt_t     op_pkt,
    output logic        res_valid,
    input  logic        res_ready,
    output res_pkt_t    res_pkt,
    output logic        redirect_valid,
    output logic [15:0] redirect_pc
);
    lane_data_t lane_res;
    logic       taken;
    logic       op_fire;

    always_comb begin
        for (int i = 0; i < `NUM_THREADS; i++) begin
            case (op_pkt.fn)
                fn_add:  lane_res[i] = op_pkt.rs1_data[i] + op_pkt.rs2_data[i];
                fn_sub:  lane_res[i] = op_pkt.rs1_data[i] - op_pkt.rs2_data[i];
                fn_and:  lane_res[i] = op_pkt.rs1_data[i] & op_pkt.rs2_data[i];
                default: lane_res[i] = op_pkt.rs1_data[i] ^ op_pkt.rs2_data[i];
            endcase
            if (!op_pkt.tmask[i] || op_pkt.is_branch) begin
                lane_res[i] = '0;
            end
        end
    end

    // branch outcome follows the last active thread only
    assign taken = op_pkt.is_branch
                && (op_pkt.rs1_data[op_pkt.last_tid] == op_pkt.rs2_data[op_pkt.last_tid]);

    assign op_ready = !res_valid || res_ready;
    assign op_fire  = op_valid && op_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            res_valid      <= 1'b0;
            redirect_valid <= 1'b0;
        end else begin
            redirect_valid <= op_fire && taken;
            if (op_fire) begin
                res_valid <= 1'b1;
            end else if (res_ready) begin
                res_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (op_fire) begin
            res_pkt.pc    <= op_pkt.pc;
            res_pkt.rd    <= op_pkt.rd;
            res_pkt.tmask <= op_pkt.tmask;
            res_pkt.wb    <= op_pkt.wb;
            res_pkt.data  <= lane_res;
            // pc counts words, same unit as the offset
            redirect_pc   <= op_pkt.pc + op_pkt.offset;
        end
    end

endmodule

// File: hw/simt_core_top.sv
// issue-and-execute slice of a four-thread simt core
// fetch packets in, one commit port and a branch redirect out
`timescale 1ns/100ps

module simt_core_top import pipe_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        in_valid,
    output logic        in_ready,
    input  fetch_pkt_t  in_pkt,
    output logic        commit_valid,
    input  logic        commit_ready,
    output res_pkt_t    commit_pkt,
    output logic        redirect_valid,
    output logic [15:0] redirect_pc
);
    logic     dec_valid;
    logic     dec_ready;
    op_pkt_t  dec_pkt;
    logic     alu_op_valid;
    logic     alu_op_ready;
    op_pkt_t  alu_op_pkt;
    logic     mul_op_valid;
    logic     mul_op_ready;
    op_pkt_t  mul_op_pkt;
    logic     alu_res_valid;
    logic     alu_res_ready;
    res_pkt_t alu_res;
    logic     mul_res_valid;
    logic     mul_res_ready;
    res_pkt_t mul_res;

    wire commit_fire = commit_valid && commit_ready;

    instr_decode decode (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_pkt    (in_pkt),
        .dec_valid (dec_valid),
        .dec_ready (dec_ready),
        .dec_pkt   (dec_pkt)
    );

    // the redirect pulse doubles as the flush
    dispatch dispatch_stage (
        .clk         (clk),
        .reset       (reset),
        .flush       (redirect_valid),
        .commit_fire (commit_fire),
        .dec_valid   (dec_valid),
        .dec_ready   (dec_ready),
        .dec_pkt     (dec_pkt),
        .alu_valid   (alu_op_valid),
        .alu_ready   (alu_op_ready),
        .alu_pkt     (alu_op_pkt),
        .mul_valid   (mul_op_valid),
        .mul_ready   (mul_op_ready),
        .mul_pkt     (mul_op_pkt)
    );

    simt_alu alu (
        .clk            (clk),
        .reset          (reset),
        .op_valid       (alu_op_valid),
        .op_ready       (alu_op_ready),
        .op_pkt         (alu_op_pkt),
        .res_valid      (alu_res_valid),
        .res_ready      (alu_res_ready),
        .res_pkt        (alu_res),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

    simt_mul mul (
        .clk       (clk),
        .reset     (reset),
        .op_valid  (mul_op_valid),
        .op_ready  (mul_op_ready),
        .op_pkt    (mul_op_pkt),
        .res_valid (mul_res_valid),
        .res_ready (mul_res_ready),
        .res_pkt   (mul_res)
    );

    result_arbiter arbiter (
        .alu_valid    (alu_res_valid),
        .alu_ready    (alu_res_ready),
        .alu_res      (alu_res),
        .mul_valid    (mul_res_valid),
        .mul_ready    (mul_res_ready),
        .mul_res      (mul_res),
        .commit_valid (commit_valid),
        .commit_ready (commit_ready),
        .commit_pkt   (commit_pkt)
    );

endmodule

// File: hw/simt_defines.svh
// global sizing for the simt issue/execute slice
// included by the packages and by any block that sizes loops or counters
`ifndef SIMT_DEFINES_SVH
`define SIMT_DEFINES_SVH

// threads per warp and lane width
`define NUM_THREADS 4
`define XLEN 16

// issue limit and execute latency
`define MAX_INFLIGHT 4
`define MUL_LATENCY 3

`endif

// File: hw/simt_mul.sv
// per-thread 16x16 multiply keeping the low lane bits
// fixed latency, holds one instruction until its result is taken
`timescale 1ns/100ps
`include "simt_defines.svh"

module simt_mul import pipe_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  logic     op_valid,
    output logic     op_ready,
    input  op_pkt_t  op_pkt,
    output logic     res_valid,
    input  logic     res_ready,
    output res_pkt_t res_pkt
);
    localparam int CNT_W = $clog2(`MUL_LATENCY + 1);

    logic             busy;
    logic [CNT_W-1:0] cnt;
    lane_data_t       prod;

    always_comb begin
        for (int i = 0; i < `NUM_THREADS; i++) begin
            prod[i] = op_pkt.tmask[i] ? op_pkt.rs1_data[i] * op_pkt.rs2_data[i] : '0;
        end
    end

    assign op_ready  = !busy;
    assign res_valid = busy && (cnt == '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= 1'b0;
            cnt  <= '0;
        end else if (op_valid && op_ready) begin
            // the accepting cycle is the first of the latency
            busy <= 1'b1;
            cnt  <= CNT_W'(`MUL_LATENCY - 1);
        end else if (res_valid && res_ready) begin
            busy <= 1'b0;
        end else if (cnt != '0) begin
            cnt <= cnt - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (op_valid && op_ready) begin
            res_pkt <= '{pc: op_pkt.pc, rd: op_pkt.rd, tmask: op_pkt.tmask,
                         wb: op_pkt.wb, data: prod};
        end
    end

endmodule

// File: hw/unit_buffer.sv
// two-entry elastic buffer in front of one execute unit
// output register plus a skid slot, flush drops both
`timescale 1ns/100ps

module unit_buffer import pipe_pkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  logic    flush,
    input  logic    valid_in,
    output logic    ready_in,
    input  op_pkt_t data_in,
    output logic    valid_out,
    input  logic    ready_out,
    output op_pkt_t data_out
);
    logic    skid_valid;
    op_pkt_t skid_data;
    logic    out_free;

    assign ready_in = !skid_valid;
    assign out_free = !valid_out || ready_out;

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            valid_out  <= 1'b0;
            skid_valid <= 1'b0;
        end else if (out_free) begin
            // skid drains first, input is held off meanwhile
            valid_out  <= skid_valid || valid_in;
            skid_valid <= 1'b0;
        end else if (valid_in && ready_in) begin
            skid_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (out_free) begin
            data_out <= skid_valid ? skid_data : data_in;
        end
        if (!out_free && valid_in && ready_in) begin
            skid_data <= data_in;
        end
    end

    // the writer never offers a packet while both slots are taken
    assert property (@(posedge clk) disable iff (reset)
        (valid_out && skid_valid) |-> !valid_in);

endmodule

// File: run_sim.sh
#!/bin/sh
# builds the testbench with verilator, runs it and checks the log
verilator --binary --timing --assert -Wno-fatal --top-module tb_simt_core \
    -f sources.f -o tb_simt_core || exit 1
./obj_dir/tb_simt_core > sim.log 2>&1
cat sim.log
grep -q "Errors found" sim.log && exit 1 || grep -q "No errors" sim.log || exit 1

// File: sources.f
+incdir+hw
hw/isa_pkg.sv
hw/pipe_pkg.sv
hw/instr_decode.sv
hw/issue_staller.sv
hw/unit_buffer.sv
hw/dispatch.sv
hw/simt_alu.sv
hw/simt_mul.sv
hw/result_arbiter.sv
hw/simt_core_top.sv
testbench/tb_simt_core.sv

// File: testbench/tb_simt_core.sv
// self-checking testbench for the simt issue/execute slice
// feeds a fixed table of alu, mul and beq packets through the fetch handshake,
// applies random commit back-pressure and matches every commit and redirect
// against the expected values stored next to each packet
`timescale 1ns/100ps
`include "simt_defines.svh"

module tb_simt_core import isa_pkg::*, pipe_pkg::*;;
    localparam int NUM_ENTRIES    = 14;
    localparam int RESET_CYCLES   = 8;
    localparam int TIMEOUT_CYCLES = 40 * NUM_ENTRIES + RESET_CYCLES;
    localparam int DRAIN_CYCLES   = 20;

    // one table row: stimulus plus what should come out for it
    typedef struct packed {
        fetch_pkt_t  pkt;
        res_pkt_t    exp;
        logic        is_branch;
        logic        is_mul;
        logic        taken;
        logic [15:0] target;
    } entry_t;

    logic        clk;
    logic        reset;
    logic        in_valid;
    logic        in_ready;
    fetch_pkt_t  in_pkt;
    logic        commit_valid;
    logic        commit_ready;
    res_pkt_t    commit_pkt;
    logic        redirect_valid;
    logic [15:0] redirect_pc;

    entry_t      stim [NUM_ENTRIES];
    bit          seen [NUM_ENTRIES];
    int          redirect_seen [NUM_ENTRIES];
    int          last_in_unit [2];
    int          fill_count;
    int          commit_count;
    int          error_count;
    int          cycle_count;
    int          drive_idx;
    int          open_branch;
    int          xfers_after_branch;
    logic [31:0] rng_state;

    simt_core_top uut (
        .clk            (clk),
        .reset          (reset),
        .in_valid       (in_valid),
        .in_ready       (in_ready),
        .in_pkt         (in_pkt),
        .commit_valid   (commit_valid),
        .commit_ready   (commit_ready),
        .commit_pkt     (commit_pkt),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

    always #50 clk = ~clk;

    task automatic fail_test(input string msg);
        error_count++;
        $display("%s", msg);
        $display("Errors found");
        $fatal(1);
    endtask

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic push_entry(input logic [31:0] word, input logic [15:0] pc,
                              input logic [3:0] tmask, input lane_data_t rs1,
                              input lane_data_t rs2, input logic [4:0] rd,
                              input lane_data_t result, input logic taken,
                              input logic [15:0] target);
        entry_t e;
        e              = '0;
        e.pkt.instr    = word;
        e.pkt.tmask    = tmask;
        e.pkt.pc       = pc;
        e.pkt.rs1_data = rs1;
        e.pkt.rs2_data = rs2;
        e.is_branch    = (word[31:28] == op_beq);
        e.is_mul       = (word[31:28] == op_mul);
        // branches commit with no writeback and zero lane data
        e.exp.pc       = pc;
        e.exp.rd       = rd;
        e.exp.tmask    = tmask;
        e.exp.wb       = !e.is_branch;
        e.exp.data     = result;
        e.taken        = taken;
        e.target       = target;
        stim[fill_count] = e;
        fill_count++;
    endtask

    task automatic add_alu(input logic [15:0] pc, input alu_fn_t fn, input logic [4:0] rd,
                           input logic [3:0] tmask, input lane_data_t rs1,
                           input lane_data_t rs2, input lane_data_t result);
        push_entry({op_alu, rd, fn, 21'd0}, pc, tmask, rs1, rs2, rd, result, 1'b0, 16'h0);
    endtask

    task automatic add_mul(input logic [15:0] pc, input logic [4:0] rd,
                           input logic [3:0] tmask, input lane_data_t rs1,
                           input lane_data_t rs2, input lane_data_t result);
        push_entry({op_mul, rd, fn_add, 21'd0}, pc, tmask, rs1, rs2, rd, result, 1'b0, 16'h0);
    endtask

    task automatic add_beq(input logic [15:0] pc, input logic [15:0] offset,
                           input logic [3:0] tmask, input lane_data_t rs1,
                           input lane_data_t rs2, input logic taken,
                           input logic [15:0] target);
        push_entry({op_beq, 12'd0, offset}, pc, tmask, rs1, rs2, 5'd0, '0, taken, target);
    endtask

    function automatic int find_entry(input logic [15:0] pc);
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            if (stim[i].pkt.pc == pc) begin
                return i;
            end
        end
        return -1;
    endfunction

    task automatic check_commit();
        int idx;
        int unit;
        idx = find_entry(commit_pkt.pc);
        assert (idx >= 0)
            else fail_test($sformatf("commit with unknown pc %h", commit_pkt.pc));
        assert (!seen[idx])
            else fail_test($sformatf("pc %h committed a second time", commit_pkt.pc));
        assert (commit_pkt.rd == stim[idx].exp.rd)
            else fail_test($sformatf("Mismatch commit_pkt.rd at pc %h: got %h expected %h",
                                     commit_pkt.pc, commit_pkt.rd, stim[idx].exp.rd));
        assert (commit_pkt.wb == stim[idx].exp.wb)
            else fail_test($sformatf("Mismatch commit_pkt.wb at pc %h: got %h expected %h",
                                     commit_pkt.pc, commit_pkt.wb, stim[idx].exp.wb));
        assert (commit_pkt.tmask == stim[idx].exp.tmask)
            else fail_test($sformatf("Mismatch commit_pkt.tmask at pc %h: got %h expected %h",
                                     commit_pkt.pc, commit_pkt.tmask, stim[idx].exp.tmask));
        for (int l = 0; l < `NUM_THREADS; l++) begin
            assert (commit_pkt.data[l] == stim[idx].exp.data[l])
                else fail_test($sformatf("Mismatch commit_pkt.data[%0d] at pc %h: got %h expected %h",
                                         l, commit_pkt.pc, commit_pkt.data[l],
                                         stim[idx].exp.data[l]));
        end
        unit = stim[idx].is_mul ? 1 : 0;
        assert (idx > last_in_unit[unit])
            else fail_test($sformatf("pc %h committed out of order within its unit",
                                     commit_pkt.pc));
        // nothing younger than an open branch may get through first
        assert (open_branch < 0 || idx <= open_branch)
            else fail_test($sformatf("pc %h committed while an older branch was in flight",
                                     commit_pkt.pc));
        if (idx == open_branch) begin
            open_branch = -1;
        end
        last_in_unit[unit] = idx;
        seen[idx] = 1'b1;
        commit_count++;
    endtask

    // the taken branch sits alone at the commit port during its redirect pulse
    task automatic check_redirect();
        int idx;
        idx = find_entry(commit_pkt.pc);
        assert (commit_valid && idx >= 0)
            else fail_test("redirect pulse without a branch result at the commit port");
        assert (stim[idx].taken)
            else fail_test($sformatf("redirect from pc %h whose branch is not taken",
                                     commit_pkt.pc));
        assert (redirect_pc == stim[idx].target)
            else fail_test($sformatf("Mismatch redirect_pc at pc %h: got %h expected %h",
                                     commit_pkt.pc, redirect_pc, stim[idx].target));
        redirect_seen[idx]++;
    endtask

    // decode may take one packet past an issued branch, then must hold
    task automatic note_transfer();
        if (open_branch >= 0) begin
            xfers_after_branch++;
            assert (xfers_after_branch <= 1)
                else fail_test("second instruction accepted before the branch committed");
        end
        if (stim[drive_idx].is_branch) begin
            open_branch        = drive_idx;
            xfers_after_branch = 0;
        end
    endtask

    // outputs are sampled mid-cycle, away from the driving edge
    always @(negedge clk) begin
        if (!reset) begin
            if (commit_valid && commit_ready) begin
                check_commit();
            end
            if (redirect_valid) begin
                check_redirect();
            end
            if (in_valid && in_ready) begin
                note_transfer();
            end
        end
    end

    // commit back-pressure, ready about 70% of cycles
    always @(posedge clk) begin
        rng_state = lcg_next(rng_state);
        commit_ready <= (rng_state[30:16] % 15'd100) < 15'd70;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            fail_test($sformatf("timeout after %0d cycles with %0d of %0d commits",
                                cycle_count, commit_count, NUM_ENTRIES));
        end
    end

    initial begin
        clk                = 1'b0;
        reset              = 1'b1;
        in_valid           = 1'b0;
        in_pkt             = '0;
        commit_ready       = 1'b0;
        rng_state          = 32'd36;
        fill_count         = 0;
        commit_count       = 0;
        error_count        = 0;
        cycle_count        = 0;
        drive_idx          = 0;
        open_branch        = -1;
        xfers_after_branch = 0;
        last_in_unit[0]    = -1;
        last_in_unit[1]    = -1;
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            seen[i]          = 1'b0;
            redirect_seen[i] = 0;
        end

        // lanes are written lane 3 first
        add_alu(16'h0100, fn_add, 5'd1, 4'b1111, 64'h0001_0002_0003_0004,
                64'h0010_0020_0030_0040, 64'h0011_0022_0033_0044);
        add_alu(16'h0101, fn_sub, 5'd2, 4'b0101, 64'h1000_2000_3000_4000,
                64'h0001_0002_0003_0004, 64'h0000_1ffe_0000_3ffc);
        add_alu(16'h0102, fn_and, 5'd3, 4'b1000, 64'hf0f0_ffff_ffff_ffff,
                64'h0ff0_1234_1234_1234, 64'h00f0_0000_0000_0000);
        add_alu(16'h0103, fn_xor, 5'd4, 4'b0011, 64'haaaa_aaaa_aaaa_5555,
                64'h5555_5555_ffff_ffff, 64'h0000_0000_5555_aaaa);
        add_mul(16'h0104, 5'd5, 4'b1111, 64'h0002_0010_0100_ffff,
                64'h0003_0010_0100_0002, 64'h0006_0100_0000_fffe);
        add_alu(16'h0105, fn_sub, 5'd6, 4'b1110, 64'h0000_0005_0007_0009,
                64'h0001_0003_0007_0001, 64'hffff_0002_0000_0000);
        add_mul(16'h0106, 5'd7, 4'b0110, 64'h1234_00ff_0123_9999,
                64'h1234_00ff_0010_9999, 64'h0000_fe01_1230_0000);
        // last active lane 2 equal, lower lanes differ
        add_beq(16'h0107, 16'h0020, 4'b0111, 64'h0000_7777_1111_2222,
                64'h0000_7777_3333_4444, 1'b1, 16'h0127);
        add_alu(16'h0108, fn_add, 5'd8, 4'b0001, 64'h1111_2222_3333_ffff,
                64'h1111_2222_3333_0002, 64'h0000_0000_0000_0001);
        // last active lane 3 differs
        add_beq(16'h0109, 16'hfffc, 4'b1011, 64'h1111_2222_3333_4444,
                64'h1112_2222_3333_4444, 1'b0, 16'h0105);
        add_mul(16'h010a, 5'd9, 4'b1001, 64'h0003_5555_5555_8000,
                64'h0005_5555_5555_0002, 64'h000f_0000_0000_0000);
        add_beq(16'h010b, 16'hfff8, 4'b0001, 64'habcd_0000_0000_5a5a,
                64'h0000_0000_0000_5a5a, 1'b1, 16'h0103);
        add_alu(16'h010c, fn_and, 5'd10, 4'b1111, 64'hff00_0f0f_1234_ffff,
                64'hf0f0_00ff_ffff_0000, 64'hf000_000f_1234_0000);
        add_mul(16'h010d, 5'd11, 4'b1100, 64'h0100_0007_0002_0003,
                64'h0100_0009_0004_0005, 64'h0000_003f_0000_0000);

        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        assert (commit_valid == 1'b0)
            else fail_test($sformatf("Mismatch commit_valid after reset: got %h expected 0",
                                     commit_valid));
        assert (redirect_valid == 1'b0)
            else fail_test($sformatf("Mismatch redirect_valid after reset: got %h expected 0",
                                     redirect_valid));
        assert (in_ready == 1'b1)
            else fail_test($sformatf("Mismatch in_ready after reset: got %h expected 1",
                                     in_ready));

        for (int i = 0; i < NUM_ENTRIES; i++) begin
            @(posedge clk);
            drive_idx = i;
            in_valid <= 1'b1;
            in_pkt   <= stim[i].pkt;
            @(negedge clk);
            while (!in_ready) begin
                @(negedge clk);
            end
        end
        @(posedge clk);
        in_valid <= 1'b0;

        wait (commit_count == NUM_ENTRIES);
        // idle a while to catch stray commits or redirects
        repeat (DRAIN_CYCLES) @(posedge clk);
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            assert (redirect_seen[i] == (stim[i].taken ? 1 : 0))
                else fail_test($sformatf("pc %h saw %0d redirects", stim[i].pkt.pc,
                                         redirect_seen[i]));
        end

        if (error_count == 0) begin
            $display("No errors");
            $finish;
        end else begin
            $display("Errors found");
            $fatal(1);
        end
    end

endmodule
